// ==== src/vio_pkg.sv ====
// shared video/io definitions; the address map assumes a 16-bit Z80-style bus and a 32x32 tile map
package vio_pkg;

	// board variant
	typedef enum logic [1:0] {
		HW_STANDARD = 2'd0,
		HW_ALT      = 2'd1
	} hw_type_t;

	// cpu address map
	localparam logic [15:0] ADR_FGV_BASE = 16'hC000;
	localparam logic [15:0] ADR_BGV_BASE = 16'hC800;
	localparam logic [15:0] ADR_PAL_BASE = 16'hD800;
	localparam logic [15:0] ADR_IO_BASE  = 16'hA000;
	localparam logic [15:0] ADR_STD_SCRX = 16'hA002;
	localparam logic [15:0] ADR_STD_SCRY = 16'hA003;
	localparam logic [15:0] ADR_ALT_SCRX = 16'hE000;
	localparam logic [15:0] ADR_ALT_SCRY = 16'hE001;

	// offsets inside the port block
	localparam logic [2:0] IO_DSW1 = 3'd0;
	localparam logic [2:0] IO_DSW2 = 3'd1;
	localparam logic [2:0] IO_CTR1 = 3'd2;
	localparam logic [2:0] IO_CTR2 = 3'd3;
	localparam logic [2:0] IO_STAT = 3'd4;

	// screen geometry
	localparam int MAP_TILES   = 32;
	localparam int TILE_PX     = 8;
	localparam int TILE_BITS   = $clog2(TILE_PX);
	localparam int PAL_ENTRIES = 32;
	localparam int VBLANK_LINE = 224;

	// tile map entry, code 0 is a transparent fg tile
	typedef struct packed {
		logic [3:0] unused;
		logic [3:0] colour;
		logic [7:0] code;
	} map_word_t;

	typedef struct packed {
		logic [4:0] row;
		logic [4:0] col;
	} map_addr_t;

	// layer 0 is fg, 1 is bg
	typedef struct packed {
		logic       layer;
		logic [3:0] colour;
	} pal_index_t;

endpackage

// ==== src/vio_addr_decode.sv ====
// combinational chip selects; scroll selects are write-only and move with the board variant
`timescale 1ns/1ps

module vio_addr_decode
	import vio_pkg::*;
#(
	parameter hw_type_t HW_TYPE = HW_STANDARD
) (
	input  logic [15:0] cp_adr,
	input  logic        cp_sel,
	input  logic        cp_wrt,
	output logic        cs_fgv,
	output logic        cs_bgv,
	output logic        cs_pal,
	output logic        cs_io,
	output logic        cs_scrx,
	output logic        cs_scry
);

	localparam logic [15:0] SCRX_ADR = (HW_TYPE == HW_ALT) ? ADR_ALT_SCRX : ADR_STD_SCRX;
	localparam logic [15:0] SCRY_ADR = (HW_TYPE == HW_ALT) ? ADR_ALT_SCRY : ADR_STD_SCRY;

	logic scr_wrt;
	logic hit_fgv;
	logic hit_bgv;
	logic hit_pal;
	logic hit_io;

	// 2 KB map windows, byte lane in bit 10
	assign hit_fgv = (cp_adr[15:11] == ADR_FGV_BASE[15:11]);
	assign hit_bgv = (cp_adr[15:11] == ADR_BGV_BASE[15:11]);

	// 32 palette bytes
	assign hit_pal = (cp_adr[15:5] == ADR_PAL_BASE[15:5]);

	// 8-byte port block, upper offsets read back as 0xff
	assign hit_io = (cp_adr[15:3] == ADR_IO_BASE[15:3]);

	// standard scroll sits on the ctr1/ctr2 addresses, only a write hits it
	assign scr_wrt = (HW_TYPE == HW_ALT) ? 1'b1 : cp_wrt;

	assign cs_fgv  = cp_sel && hit_fgv;
	assign cs_bgv  = cp_sel && hit_bgv;
	assign cs_pal  = cp_sel && hit_pal;
	assign cs_io   = cp_sel && hit_io;
	assign cs_scrx = cp_sel && scr_wrt && (cp_adr == SCRX_ADR);
	assign cs_scry = cp_sel && scr_wrt && (cp_adr == SCRY_ADR);

endmodule

// ==== src/vio_dpram.sv ====
// read-first cpu port and read-only video port, both with one cycle of read latency; no init
`timescale 1ns/1ps

module vio_dpram #(
	parameter int  ADDR_W = 10,
	parameter type DATA_T = logic [7:0]
) (
	input  logic              MCLK,
	input  logic              a_we,
	input  logic [ADDR_W-1:0] a_adr,
	input  DATA_T             a_din,
	output DATA_T             a_dout,
	input  logic [ADDR_W-1:0] b_adr,
	output DATA_T             b_dout
);

	localparam int DEPTH = 1 << ADDR_W;

	DATA_T mem [DEPTH];

	// cpu port, old data comes out on a write
	always_ff @(posedge MCLK) begin
		a_dout <= mem[a_adr];
		if (a_we) begin
			mem[a_adr] <= a_din;
		end
	end

	// video port
	always_ff @(posedge MCLK) begin
		b_dout <= mem[b_adr];
	end

endmodule

// ==== src/vio_io_ports.sv ====
// scroll registers and input ports; reads are combinational, the top registers them
`timescale 1ns/1ps

module vio_io_ports
	import vio_pkg::*;
#(
	parameter hw_type_t HW_TYPE = HW_STANDARD
) (
	input  logic       MCLK,
	input  logic       RESET,
	input  logic       cs_io,
	input  logic       cs_scrx,
	input  logic       cs_scry,
	input  logic       cp_wrt,
	input  logic [2:0] cp_adr_lo,
	input  logic [7:0] cp_odt,
	input  logic [7:0] dsw1,
	input  logic [7:0] dsw2,
	input  logic [7:0] ctr1,
	input  logic [7:0] ctr2,
	input  logic [8:0] pv,
	output logic [7:0] io_dout,
	output logic       vblk,
	output logic [7:0] scroll_x,
	output logic [7:0] scroll_y
);

	logic ld_x;
	logic ld_y;

	assign ld_x = cs_scrx && cp_wrt;
	assign ld_y = cs_scry && cp_wrt;

	always_ff @(posedge MCLK) begin
		if (RESET) begin
			scroll_x <= 8'h00;
			scroll_y <= 8'h00;
		end else begin
			if (ld_x) begin
				scroll_x <= cp_odt;
			end
			if (ld_y) begin
				scroll_y <= cp_odt;
			end
		end
	end

	assign vblk = (pv >= 9'(VBLANK_LINE));

	always_comb begin
		io_dout = 8'hFF;
		if (cs_io) begin
			case (cp_adr_lo)
				IO_DSW1: io_dout = dsw1;
				IO_DSW2: io_dout = dsw2;
				IO_CTR1: io_dout = ctr1;
				IO_CTR2: io_dout = ctr2;
				IO_STAT: io_dout = {7'b0000000, vblk};
				default: io_dout = 8'hFF;
			endcase
		end
	end

endmodule

// ==== src/vio_tile_render.sv ====
// fixed 3-cycle pixel pipeline, no stall; map and palette rams must have one cycle read latency
`timescale 1ns/1ps

module vio_tile_render
	import vio_pkg::*;
(
	input  logic       MCLK,
	input  logic       RESET,
	input  logic       pclk_en,
	input  logic [8:0] ph,
	input  logic [8:0] pv,
	input  logic [7:0] scroll_x,
	input  logic [7:0] scroll_y,
	output map_addr_t  fg_adr,
	output map_addr_t  bg_adr,
	input  map_word_t  fg_word,
	input  map_word_t  bg_word,
	output pal_index_t pal_adr,
	input  logic [7:0] pal_colour,
	output logic [7:0] pout,
	output logic       pout_valid
);

	logic [7:0] bg_x;
	logic [7:0] bg_y;
	logic       adr_valid;
	logic       word_valid;
	logic       colour_valid;

	// scrolled bg position, wraps at 256
	assign bg_x = ph[7:0] + scroll_x;
	assign bg_y = pv[7:0] + scroll_y;

	// stage 1: map addresses
	always_ff @(posedge MCLK) begin
		if (pclk_en) begin
			fg_adr.row <= pv[7:TILE_BITS];
			fg_adr.col <= ph[7:TILE_BITS];
			bg_adr.row <= bg_y[7:TILE_BITS];
			bg_adr.col <= bg_x[7:TILE_BITS];
		end
	end

	// stage 2: map words arrive, pick the layer
	always_comb begin
		if (fg_word.code != 8'h00) begin
			pal_adr.layer  = 1'b0;
			pal_adr.colour = fg_word.colour;
		end else begin
			pal_adr.layer  = 1'b1;
			pal_adr.colour = bg_word.colour;
		end
	end

	// stage 3: palette colour arrives, register it out
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			pout <= 8'h00;
		end else if (colour_valid) begin
			pout <= pal_colour;
		end
	end

	// validity follows the data through the rams
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			adr_valid    <= 1'b0;
			word_valid   <= 1'b0;
			colour_valid <= 1'b0;
			pout_valid   <= 1'b0;
		end else begin
			adr_valid    <= pclk_en;
			word_valid   <= adr_valid;
			colour_valid <= word_valid;
			pout_valid   <= colour_valid;
		end
	end

endmodule

// ==== src/vio_io_video.sv ====
// video and io block top; cp_idt holds the last read, beam timing comes from outside
`timescale 1ns/1ps

module vio_io_video
	import vio_pkg::*;
#(
	parameter hw_type_t HW_TYPE = HW_STANDARD
) (
	input  logic        MCLK,
	input  logic        RESET,
	input  logic        pclk_en,
	input  logic [8:0]  ph,
	input  logic [8:0]  pv,
	input  logic [15:0] cp_adr,
	input  logic [7:0]  cp_odt,
	output logic [7:0]  cp_idt,
	input  logic        cp_red,
	input  logic        cp_wrt,
	input  logic        cp_sel,
	input  logic [7:0]  dsw1,
	input  logic [7:0]  dsw2,
	input  logic [7:0]  ctr1,
	input  logic [7:0]  ctr2,
	output logic        vblk,
	output logic [7:0]  pout,
	output logic        pout_valid
);

	localparam int MAP_W = $clog2(MAP_TILES * MAP_TILES);
	localparam int PAL_W = $clog2(PAL_ENTRIES);

	logic cs_fgv;
	logic cs_bgv;
	logic cs_pal;
	logic cs_io;
	logic cs_scrx;
	logic cs_scry;

	logic [7:0] io_dout;
	logic [7:0] scroll_x;
	logic [7:0] scroll_y;

	map_addr_t  fg_adr;
	map_addr_t  bg_adr;
	map_word_t  fg_word;
	map_word_t  bg_word;
	pal_index_t pal_adr;
	logic [7:0] pal_colour;

	logic [7:0] fg_lo_dat;
	logic [7:0] fg_hi_dat;
	logic [7:0] bg_lo_dat;
	logic [7:0] bg_hi_dat;
	logic [7:0] pal_dat;

	logic [MAP_W-1:0] bg_ofs;
	logic [MAP_W-1:0] bg_cpu_adr;

	logic fg_lo_we;
	logic fg_hi_we;
	logic bg_lo_we;
	logic bg_hi_we;
	logic pal_we;

	logic       rd_go;
	logic       rd_pend;
	logic       rd_io;
	logic       rd_fg;
	logic       rd_bg;
	logic       rd_pal;
	logic       rd_hi;
	logic [7:0] rd_io_dat;
	logic [7:0] rd_mux;
	logic [7:0] idt_hold;

	vio_addr_decode #(.HW_TYPE(HW_TYPE)) u_dec (
		.cp_adr (cp_adr),
		.cp_sel (cp_sel),
		.cp_wrt (cp_wrt),
		.cs_fgv (cs_fgv),
		.cs_bgv (cs_bgv),
		.cs_pal (cs_pal),
		.cs_io  (cs_io),
		.cs_scrx(cs_scrx),
		.cs_scry(cs_scry)
	);

	vio_io_ports #(.HW_TYPE(HW_TYPE)) u_io (
		.MCLK     (MCLK),
		.RESET    (RESET),
		.cs_io    (cs_io),
		.cs_scrx  (cs_scrx),
		.cs_scry  (cs_scry),
		.cp_wrt   (cp_wrt),
		.cp_adr_lo(cp_adr[2:0]),
		.cp_odt   (cp_odt),
		.dsw1     (dsw1),
		.dsw2     (dsw2),
		.ctr1     (ctr1),
		.ctr2     (ctr2),
		.pv       (pv),
		.io_dout  (io_dout),
		.vblk     (vblk),
		.scroll_x (scroll_x),
		.scroll_y (scroll_y)
	);

	vio_tile_render u_render (
		.MCLK      (MCLK),
		.RESET     (RESET),
		.pclk_en   (pclk_en),
		.ph        (ph),
		.pv        (pv),
		.scroll_x  (scroll_x),
		.scroll_y  (scroll_y),
		.fg_adr    (fg_adr),
		.bg_adr    (bg_adr),
		.fg_word   (fg_word),
		.bg_word   (bg_word),
		.pal_adr   (pal_adr),
		.pal_colour(pal_colour),
		.pout      (pout),
		.pout_valid(pout_valid)
	);

	// standard board shifts cpu bg access by the scroll tile position
	assign bg_ofs     = cp_adr[MAP_W-1:0] + {scroll_y[7:3], scroll_x[7:3]};
	assign bg_cpu_adr = (HW_TYPE == HW_STANDARD) ? bg_ofs : cp_adr[MAP_W-1:0];

	// byte lanes from bit 10
	assign fg_lo_we = cs_fgv && cp_wrt && !cp_adr[10];
	assign fg_hi_we = cs_fgv && cp_wrt && cp_adr[10];
	assign bg_lo_we = cs_bgv && cp_wrt && !cp_adr[10];
	assign bg_hi_we = cs_bgv && cp_wrt && cp_adr[10];
	assign pal_we   = cs_pal && cp_wrt;

	vio_dpram #(.ADDR_W(MAP_W), .DATA_T(logic [7:0])) u_fgv_lo (
		.MCLK(MCLK), .a_we(fg_lo_we), .a_adr(cp_adr[MAP_W-1:0]), .a_din(cp_odt),
		.a_dout(fg_lo_dat), .b_adr(fg_adr), .b_dout(fg_word[7:0])
	);

	vio_dpram #(.ADDR_W(MAP_W), .DATA_T(logic [7:0])) u_fgv_hi (
		.MCLK(MCLK), .a_we(fg_hi_we), .a_adr(cp_adr[MAP_W-1:0]), .a_din(cp_odt),
		.a_dout(fg_hi_dat), .b_adr(fg_adr), .b_dout(fg_word[15:8])
	);

	vio_dpram #(.ADDR_W(MAP_W), .DATA_T(logic [7:0])) u_bgv_lo (
		.MCLK(MCLK), .a_we(bg_lo_we), .a_adr(bg_cpu_adr), .a_din(cp_odt),
		.a_dout(bg_lo_dat), .b_adr(bg_adr), .b_dout(bg_word[7:0])
	);

	vio_dpram #(.ADDR_W(MAP_W), .DATA_T(logic [7:0])) u_bgv_hi (
		.MCLK(MCLK), .a_we(bg_hi_we), .a_adr(bg_cpu_adr), .a_din(cp_odt),
		.a_dout(bg_hi_dat), .b_adr(bg_adr), .b_dout(bg_word[15:8])
	);

	vio_dpram #(.ADDR_W(PAL_W), .DATA_T(logic [7:0])) u_pal (
		.MCLK(MCLK), .a_we(pal_we), .a_adr(cp_adr[PAL_W-1:0]), .a_din(cp_odt),
		.a_dout(pal_dat), .b_adr(pal_adr), .b_dout(pal_colour)
	);

	assign rd_go = cp_red && cp_sel;

	// ram port a output is already the read register, so only the select is kept
	always_ff @(posedge MCLK) begin
		if (RESET) begin
			rd_pend  <= 1'b0;
			rd_io    <= 1'b0;
			rd_fg    <= 1'b0;
			rd_bg    <= 1'b0;
			rd_pal   <= 1'b0;
			idt_hold <= 8'h00;
		end else begin
			rd_pend  <= rd_go;
			idt_hold <= cp_idt;
			if (rd_go) begin
				rd_io  <= cs_io;
				rd_fg  <= cs_fgv;
				rd_bg  <= cs_bgv;
				rd_pal <= cs_pal;
			end
		end
	end

	always_ff @(posedge MCLK) begin
		if (rd_go) begin
			rd_io_dat <= io_dout;
			rd_hi     <= cp_adr[10];
		end
	end

	always_comb begin
		if (rd_io) begin
			rd_mux = rd_io_dat;
		end else if (rd_fg) begin
			rd_mux = rd_hi ? fg_hi_dat : fg_lo_dat;
		end else if (rd_bg) begin
			rd_mux = rd_hi ? bg_hi_dat : bg_lo_dat;
		end else if (rd_pal) begin
			rd_mux = pal_dat;
		end else begin
			rd_mux = 8'hFF;
		end
	end

	// hold the byte until the next read
	assign cp_idt = rd_pend ? rd_mux : idt_hold;

endmodule

// ==== dv/tb_vio_io_video.sv ====
// standard variant only; needs dv/vio_stim.txt relative to the run directory, stops at the first error
`timescale 1ns/1ps

module tb_vio_io_video
	import vio_pkg::*;
;

	logic        MCLK;
	logic        RESET;
	logic        pclk_en;
	logic [8:0]  ph;
	logic [8:0]  pv;
	logic [15:0] cp_adr;
	logic [7:0]  cp_odt;
	logic [7:0]  cp_idt;
	logic        cp_red;
	logic        cp_wrt;
	logic        cp_sel;
	logic [7:0]  dsw1;
	logic [7:0]  dsw2;
	logic [7:0]  ctr1;
	logic [7:0]  ctr2;
	logic        vblk;
	logic [7:0]  pout;
	logic        pout_valid;

	// expected pixels in issue order
	logic [7:0] exp_q [$];
	logic [7:0] exp_pix;
	logic [3:0] en_hist;
	int         limit_cycles;

	vio_io_video #(.HW_TYPE(HW_STANDARD)) dut0 (
		.MCLK      (MCLK),
		.RESET     (RESET),
		.pclk_en   (pclk_en),
		.ph        (ph),
		.pv        (pv),
		.cp_adr    (cp_adr),
		.cp_odt    (cp_odt),
		.cp_idt    (cp_idt),
		.cp_red    (cp_red),
		.cp_wrt    (cp_wrt),
		.cp_sel    (cp_sel),
		.dsw1      (dsw1),
		.dsw2      (dsw2),
		.ctr1      (ctr1),
		.ctr2      (ctr2),
		.vblk      (vblk),
		.pout      (pout),
		.pout_valid(pout_valid)
	);

	initial begin
		MCLK = 1'b0;
		forever #20 MCLK = ~MCLK;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic bus_write(input logic [15:0] adr, input logic [7:0] dat);
		@(posedge MCLK);
		pclk_en <= 1'b0;
		cp_sel  <= 1'b1;
		cp_wrt  <= 1'b1;
		cp_adr  <= adr;
		cp_odt  <= dat;
		@(posedge MCLK);
		cp_sel  <= 1'b0;
		cp_wrt  <= 1'b0;
	endtask

	// data is registered, so it shows one cycle after the strobe
	task automatic bus_read_check(input logic [15:0] adr, input logic [7:0] exp);
		@(posedge MCLK);
		pclk_en <= 1'b0;
		cp_sel  <= 1'b1;
		cp_red  <= 1'b1;
		cp_adr  <= adr;
		@(posedge MCLK);
		cp_sel  <= 1'b0;
		cp_red  <= 1'b0;
		@(negedge MCLK);
		assert (cp_idt === exp) else
			abort_run($sformatf("FAIL cp_idt at %04h: got %02h expected %02h", adr, cp_idt, exp));
		// the status port mirrors the vblk pin
		if (adr == ADR_IO_BASE + 16'(IO_STAT)) begin
			assert (vblk === exp[0]) else
				abort_run($sformatf("FAIL vblk: got %0h expected %0h", vblk, exp[0]));
		end
	endtask

	task automatic set_switches(input logic [7:0] d1, input logic [7:0] d2,
		input logic [7:0] c1, input logic [7:0] c2);
		@(posedge MCLK);
		pclk_en <= 1'b0;
		dsw1    <= d1;
		dsw2    <= d2;
		ctr1    <= c1;
		ctr2    <= c2;
	endtask

	task automatic pixel_sample(input logic [8:0] h, input logic [8:0] v, input logic [7:0] exp);
		@(posedge MCLK);
		pclk_en <= 1'b1;
		ph      <= h;
		pv      <= v;
		exp_q.push_back(exp);
	endtask

	// pout_valid must follow each sample by exactly 3 cycles
	always @(negedge MCLK) begin
		if (!RESET) begin
			assert (pout_valid === en_hist[3]) else
				abort_run($sformatf("FAIL pout_valid: got %0h expected %0h",
					pout_valid, en_hist[3]));
			if (pout_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					abort_run("pout_valid pulsed with no pixel outstanding");
				end
				exp_pix = exp_q.pop_front();
				assert (pout === exp_pix) else
					abort_run($sformatf("FAIL pout: got %02h expected %02h", pout, exp_pix));
			end
			en_hist = {en_hist[2:0], pclk_en};
		end
	end

	// watchdog sized from the stim length
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge MCLK);
		abort_run($sformatf("timeout: stimulus did not finish within %0d cycles", limit_cycles));
	end

	initial begin
		int            fd;
		int            code;
		int            n_lines;
		logic [7:0]    op;
		logic [31:0]   v0;
		logic [31:0]   v1;
		logic [31:0]   v2;
		logic [31:0]   v3;
		logic [2047:0] line_buf;
		bit            done;

		limit_cycles = 0;
		en_hist      = 4'h0;
		RESET        = 1'b1;
		pclk_en      = 1'b0;
		ph           = 9'h000;
		pv           = 9'h000;
		cp_adr       = 16'h0000;
		cp_odt       = 8'h00;
		cp_red       = 1'b0;
		cp_wrt       = 1'b0;
		cp_sel       = 1'b0;
		dsw1         = 8'h00;
		dsw2         = 8'h00;
		ctr1         = 8'h00;
		ctr2         = 8'h00;

		// first pass only counts lines
		n_lines = 0;
		fd = $fopen("dv/vio_stim.txt", "r");
		if (fd == 0) begin
			abort_run("could not open dv/vio_stim.txt");
		end
		while (!$feof(fd)) begin
			code = $fgets(line_buf, fd);
			if (code > 0) begin
				n_lines++;
			end
		end
		$fclose(fd);
		limit_cycles = n_lines * 20 + 16;

		repeat (16) @(posedge MCLK);
		RESET <= 1'b0;
		@(negedge MCLK);
		assert (pout_valid === 1'b0) else
			abort_run($sformatf("FAIL pout_valid: got %0h expected 0", pout_valid));
		assert (cp_idt === 8'h00) else
			abort_run($sformatf("FAIL cp_idt: got %02h expected 00", cp_idt));

		fd = $fopen("dv/vio_stim.txt", "r");
		done = 1'b0;
		while (!done) begin
			code = $fscanf(fd, " %c", op);
			if (code != 1) begin
				done = 1'b1;
			end else if (op == "#") begin
				code = $fgets(line_buf, fd);
			end else if (op == "W" || op == "R") begin
				code = $fscanf(fd, "%h %h", v0, v1);
				if (code != 2) begin
					abort_run("malformed bus line in stim file");
				end
				if (op == "W") begin
					bus_write(v0[15:0], v1[7:0]);
				end else begin
					bus_read_check(v0[15:0], v1[7:0]);
				end
			end else if (op == "P") begin
				code = $fscanf(fd, "%h %h %h", v0, v1, v2);
				if (code != 3) begin
					abort_run("malformed pixel line in stim file");
				end
				pixel_sample(v0[8:0], v1[8:0], v2[7:0]);
			end else if (op == "S") begin
				code = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
				if (code != 4) begin
					abort_run("malformed switch line in stim file");
				end
				set_switches(v0[7:0], v1[7:0], v2[7:0], v3[7:0]);
			end else begin
				abort_run($sformatf("unknown opcode '%c' in stim file", op));
			end
		end
		$fclose(fd);

		// let the pipeline drain, then make sure nothing else comes out
		@(posedge MCLK);
		pclk_en <= 1'b0;
		while (exp_q.size() != 0) begin
			@(negedge MCLK);
		end
		repeat (4) @(negedge MCLK);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== dv/vio_stim.txt ====
# op W: addr data | R: addr expected_byte | P: ph pv expected_pout | S: dsw1 dsw2 ctr1 ctr2
# all values hex; expected pout is the palette byte the pixel should select
S 5a a5 3c c3
R a000 5a
R a001 a5
R a002 3c
R a003 c3
R a004 00
R 8000 ff
W d805 25
W d813 93
W d81a e7
R d805 25
R d81a e7
W c041 07
W c441 05
W c022 00
W c086 00
W c3f0 00
R c041 07
R c441 05
W a002 18
W a003 10
W c822 40
W cc22 03
W c886 01
W cc86 0a
W cff0 03
R c822 40
R cc22 03
R cc86 0a
P 00c 012 25
P 010 008 93
P 030 020 e7
P 00f 017 25
P 080 0f8 93
R a004 01
R a002 3c

// ==== sim.f ====
src/vio_pkg.sv
src/vio_addr_decode.sv
src/vio_dpram.sv
src/vio_io_ports.sv
src/vio_tile_render.sv
src/vio_io_video.sv
dv/tb_vio_io_video.sv
